//--- source/ocpPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OCP 2.2 signal encodings for the master side
// Referenced by scoped name from RTL and testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package ocpPkg;

  // Request command on MCmd
  typedef logic [2:0] mCmdT;

  // Only the basic commands are issued
  localparam mCmdT cmdIdle  = 3'd0;
  localparam mCmdT cmdWrite = 3'd1;
  localparam mCmdT cmdRead  = 3'd2;

  // Slave response on SResp
  typedef logic [1:0] sRespT;

  // No response pending
  localparam sRespT respNull = 2'd0;
  // Data valid or accept
  localparam sRespT respDva  = 2'd1;
  // Request failed but data still returned
  localparam sRespT respFail = 2'd2;
  // Response error
  localparam sRespT respErr  = 2'd3;

  // Burst address sequence on MBurstSeq
  typedef logic [2:0] burstSeqT;

  // Incrementing burst, also the idle default
  localparam burstSeqT seqIncr = 3'd0;

endpackage

//--- source/bridgePkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bridge-side sizing defaults and controller state
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package bridgePkg;

  // Default width of MAddr and the bridge address
  localparam int defaultAddrWidth = 64;

  // Default width of MData, SData and bridge data
  localparam int defaultDataWidth = 8;

  // Default width of MBurstLength
  localparam int defaultBurstLenWidth = 10;

  // Request controller states
  typedef enum logic [1:0] {
    stIdle  = 2'd0,
    stWrite = 2'd1,
    stRead  = 2'd2
  } masterStateT;

endpackage

//--- source/burstCounter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Accepted beat counter for OCP request bursts
// Flags the last beat and strobes burst completion
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module burstCounter #(
  parameter int BurstLenWidth = 10
) (
  input  logic                     Clk,
  input  logic                     reset,
  input  logic                     EnableClk,
  input  logic                     burstActive,
  input  logic                     SCmdAccept,
  input  logic [BurstLenWidth-1:0] reqLength,
  input  logic                     reqSingle,
  output logic                     reqLast,
  output logic                     burstDone
);

  // Beats accepted so far in this burst
  logic [BurstLenWidth-1:0] beatCount;

  // Advance on each accepted beat
  always_ff @(posedge Clk) begin
    if (EnableClk) begin
      if (reset) begin
        beatCount <= '0;
      end else if (!burstActive) begin
        // Cleared between bursts
        beatCount <= '0;
      end else if (SCmdAccept) begin
        beatCount <= beatCount + 1'b1;
      end
    end
  end

  // Current beat is the final one
  // Single request bursts end on the first beat
  assign reqLast = (beatCount == (reqLength - 1'b1)) | reqSingle;

  // Final beat accepted by the slave
  assign burstDone = burstActive & SCmdAccept & reqLast;

endmodule

//--- source/requestFsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Idle/read/write FSM for the OCP request group
// Drives the registered Basic and Burst outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module requestFsm #(
  parameter int AddrWidth     = 64,
  parameter int DataWidth     = 8,
  parameter int BurstLenWidth = 10
) (
  input  logic                     Clk,
  input  logic                     reset,
  input  logic                     EnableClk,
  input  logic                     readRequest,
  input  logic                     writeRequest,
  input  logic [AddrWidth-1:0]     address,
  input  logic [DataWidth-1:0]     writeData,
  input  logic [BurstLenWidth-1:0] burstLength,
  input  ocpPkg::burstSeqT         burstSeq,
  input  logic                     burstSingleReq,
  input  logic                     reqLast,
  input  logic                     burstDone,
  output logic                     burstActive,
  output logic [BurstLenWidth-1:0] reqLength,
  output logic                     reqSingle,
  output ocpPkg::mCmdT             MCmd,
  output logic [AddrWidth-1:0]     MAddr,
  output logic [DataWidth-1:0]     MData,
  output logic [BurstLenWidth-1:0] MBurstLength,
  output ocpPkg::burstSeqT         MBurstSeq,
  output logic                     MBurstSingleSeq,
  output logic                     MReqLast
);

  bridgePkg::masterStateT state;
  bridgePkg::masterStateT nextState;

  // Request taken this edge
  logic burstStart;

  // Next state
  always_comb begin
    nextState = state;
    case (state)
      bridgePkg::stIdle: begin
        // Read wins when both are raised
        if (readRequest) begin
          nextState = bridgePkg::stRead;
        end else if (writeRequest) begin
          nextState = bridgePkg::stWrite;
        end
      end
      bridgePkg::stWrite, bridgePkg::stRead: begin
        // Leave once the final beat is accepted
        if (burstDone) begin
          nextState = bridgePkg::stIdle;
        end
      end
      default: begin
        nextState = bridgePkg::stIdle;
      end
    endcase
  end

  assign burstStart = (state == bridgePkg::stIdle) && (nextState != bridgePkg::stIdle);

  // State and command register
  // MCmd follows the state being entered
  always_ff @(posedge Clk) begin
    if (EnableClk) begin
      if (reset) begin
        state <= bridgePkg::stIdle;
        MCmd  <= ocpPkg::cmdIdle;
      end else begin
        state <= nextState;
        case (nextState)
          bridgePkg::stWrite: MCmd <= ocpPkg::cmdWrite;
          bridgePkg::stRead:  MCmd <= ocpPkg::cmdRead;
          default:            MCmd <= ocpPkg::cmdIdle;
        endcase
      end
    end
  end

  // Request payload and burst attributes
  always_ff @(posedge Clk) begin
    if (EnableClk) begin
      if (reset) begin
        MAddr           <= '0;
        MData           <= '0;
        MBurstLength    <= BurstLenWidth'(1);
        MBurstSeq       <= ocpPkg::seqIncr;
        MBurstSingleSeq <= 1'b0;
      end else begin
        // Address tracks the bridge on every active beat
        MAddr <= (nextState != bridgePkg::stIdle) ? address : '0;
        // Write data only, zero for reads and idle
        MData <= (nextState == bridgePkg::stWrite) ? writeData : '0;
        // Attributes captured once per burst
        if (burstStart) begin
          MBurstLength    <= burstLength;
          MBurstSeq       <= burstSeq;
          MBurstSingleSeq <= burstSingleReq;
        end
      end
    end
  end

  assign burstActive = (state != bridgePkg::stIdle);

  // Captured attributes feed the beat counter
  assign reqLength = MBurstLength;
  assign reqSingle = MBurstSingleSeq;

  // Last beat flag from counter state
  // Held low outside a burst
  assign MReqLast = burstActive & reqLast;

endmodule

//--- source/ocpMaster.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OCP 2.2 master request controller top level
// Bridge requests in, OCP request group out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module ocpMaster #(
  parameter int AddrWidth     = bridgePkg::defaultAddrWidth,
  parameter int DataWidth     = bridgePkg::defaultDataWidth,
  parameter int BurstLenWidth = bridgePkg::defaultBurstLenWidth
) (
  input  logic                     Clk,
  input  logic                     reset,
  input  logic                     EnableClk,
  // Bridge side
  input  logic                     readRequest,
  input  logic                     writeRequest,
  input  logic [AddrWidth-1:0]     address,
  input  logic [DataWidth-1:0]     writeData,
  input  logic [BurstLenWidth-1:0] burstLength,
  input  ocpPkg::burstSeqT         burstSeq,
  input  logic                     burstSingleReq,
  output logic [DataWidth-1:0]     readData,
  // OCP slave inputs
  input  logic                     SCmdAccept,
  input  ocpPkg::sRespT            SResp,
  input  logic [DataWidth-1:0]     SData,
  // OCP request group
  output ocpPkg::mCmdT             MCmd,
  output logic [AddrWidth-1:0]     MAddr,
  output logic [DataWidth-1:0]     MData,
  output logic [BurstLenWidth-1:0] MBurstLength,
  output ocpPkg::burstSeqT         MBurstSeq,
  output logic                     MBurstSingleSeq,
  output logic                     MReqLast
);

  // FSM to counter
  logic                     burstActive;
  logic [BurstLenWidth-1:0] reqLength;
  logic                     reqSingle;
  // Counter to FSM
  logic                     reqLast;
  logic                     burstDone;

  requestFsm #(
    .AddrWidth     (AddrWidth),
    .DataWidth     (DataWidth),
    .BurstLenWidth (BurstLenWidth)
  ) fsm (
    .Clk             (Clk),
    .reset           (reset),
    .EnableClk       (EnableClk),
    .readRequest     (readRequest),
    .writeRequest    (writeRequest),
    .address         (address),
    .writeData       (writeData),
    .burstLength     (burstLength),
    .burstSeq        (burstSeq),
    .burstSingleReq  (burstSingleReq),
    .reqLast         (reqLast),
    .burstDone       (burstDone),
    .burstActive     (burstActive),
    .reqLength       (reqLength),
    .reqSingle       (reqSingle),
    .MCmd            (MCmd),
    .MAddr           (MAddr),
    .MData           (MData),
    .MBurstLength    (MBurstLength),
    .MBurstSeq       (MBurstSeq),
    .MBurstSingleSeq (MBurstSingleSeq),
    .MReqLast        (MReqLast)
  );

  burstCounter #(
    .BurstLenWidth (BurstLenWidth)
  ) counter (
    .Clk         (Clk),
    .reset       (reset),
    .EnableClk   (EnableClk),
    .burstActive (burstActive),
    .SCmdAccept  (SCmdAccept),
    .reqLength   (reqLength),
    .reqSingle   (reqSingle),
    .reqLast     (reqLast),
    .burstDone   (burstDone)
  );

  // Response decode
  // DVA and FAIL both carry data, anything else reads as zero
  always_comb begin
    case (SResp)
      ocpPkg::respDva:  readData = SData;
      ocpPkg::respFail: readData = SData;
      default:          readData = '0;
    endcase
  end

endmodule

//--- sim/ocpMaster_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Request-phase checks, bound into ocpMaster
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module ocpMasterAssert #(
  parameter int AddrWidth     = 64,
  parameter int DataWidth     = 8,
  parameter int BurstLenWidth = 10
) (
  input logic                     Clk, reset, EnableClk,
  input logic                     readRequest, writeRequest, burstSingleReq, SCmdAccept,
  input logic [AddrWidth-1:0]     address, MAddr,
  input logic [BurstLenWidth-1:0] burstLength, MBurstLength,
  input ocpPkg::burstSeqT         burstSeq, MBurstSeq,
  input ocpPkg::sRespT            SResp,
  input logic [DataWidth-1:0]     SData, readData, MData, writeData,
  input ocpPkg::mCmdT             MCmd,
  input logic                     MBurstSingleSeq, MReqLast
);

  // Failed checks so far
  int failCount = 0;
  // Beats accepted in the running burst
  logic [BurstLenWidth-1:0] beats;
  logic                     active;

  assign active = (MCmd != ocpPkg::cmdIdle);

  // A beat ends on an enabled edge with SCmdAccept while MCmd is not idle
  always @(posedge Clk) begin
    if (reset || (EnableClk && !active)) begin
      beats <= '0;
    end else if (EnableClk && SCmdAccept) begin
      beats <= beats + BurstLenWidth'(1);
    end
  end

  function automatic void countFailure(input string what);
    $error("%s", what);
    failCount++;
  endfunction

  // Reset leaves the request group idle with default attributes
  resetValues: assert property (@(posedge Clk)
    $past(reset && EnableClk) |-> !active && !MReqLast && MAddr == '0 && MData == '0 &&
      MBurstLength == BurstLenWidth'(1) && MBurstSeq == ocpPkg::seqIncr && !MBurstSingleSeq)
    else countFailure("request outputs not at their reset values");

  // Request in idle opens the burst next cycle, read first
  startBurst: assert property (@(posedge Clk) disable iff (reset)
    EnableClk && !active && (readRequest || writeRequest) |=>
      MCmd == ($past(readRequest) ? ocpPkg::cmdRead : ocpPkg::cmdWrite) &&
      MBurstLength == $past(burstLength) && MBurstSeq == $past(burstSeq) &&
      MBurstSingleSeq == $past(burstSingleReq))
    else countFailure("burst did not start with the requested command and attributes");

  // No request taken, so no burst
  idleHold: assert property (@(posedge Clk) disable iff (reset)
    !active && !(EnableClk && (readRequest || writeRequest)) |=> !active)
    else countFailure("MCmd left idle without a request");

  // Hold until the last beat is accepted on an enabled edge, then idle
  burstProgress: assert property (@(posedge Clk) disable iff (reset)
    active |=> MCmd == ($past(EnableClk && SCmdAccept && MReqLast) ?
      ocpPkg::cmdIdle : $past(MCmd)))
    else countFailure("MCmd changed other than after the last accepted beat");

  // Address and write data track the bridge on every enabled edge
  payloadFollow: assert property (@(posedge Clk) disable iff (reset)
    EnableClk |=> (!active || MAddr == $past(address)) &&
      (MCmd != ocpPkg::cmdWrite || MData == $past(writeData)))
    else countFailure("MAddr or MData did not follow the bridge inputs");

  // Final beat is number length, every beat for a single request
  lastFlag: assert property (@(posedge Clk) disable iff (reset)
    MReqLast == (active && (MBurstSingleSeq || beats == MBurstLength - BurstLenWidth'(1))))
    else countFailure("MReqLast does not match the accepted beat count");

  readMData: assert property (@(posedge Clk) disable iff (reset)
    MCmd == ocpPkg::cmdRead |-> MData == '0)
    else countFailure("MData not zero during a read burst");

  // DVA and FAIL return data, the rest reads as zero
  readDecode: assert property (@(posedge Clk) disable iff (reset)
    readData == ((SResp == ocpPkg::respDva || SResp == ocpPkg::respFail) ? SData : '0))
    else countFailure("readData does not follow the SResp decode");

endmodule

bind ocpMaster ocpMasterAssert #(
  .AddrWidth     (AddrWidth),
  .DataWidth     (DataWidth),
  .BurstLenWidth (BurstLenWidth)
) checks (.*);

//--- sim/ocpMasterTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for ocpMaster with a random-accept slave
// Bound assertions do the protocol checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module ocpMasterTb;

  localparam int AddrWidth     = bridgePkg::defaultAddrWidth;
  localparam int DataWidth     = bridgePkg::defaultDataWidth;
  localparam int BurstLenWidth = bridgePkg::defaultBurstLenWidth;
  // Cycles before a burst is given up
  localparam int timeoutCycles = 300;

  logic                     Clk = 1'b0;
  logic                     reset, readRequest, writeRequest, burstSingleReq;
  logic [AddrWidth-1:0]     address, MAddr;
  logic [DataWidth-1:0]     writeData, readData, MData;
  logic [BurstLenWidth-1:0] burstLength, MBurstLength;
  ocpPkg::burstSeqT         burstSeq, MBurstSeq;
  ocpPkg::mCmdT             MCmd;
  logic                     MBurstSingleSeq, MReqLast;
  // Driven only from the posedge process below
  logic                     EnableClk = 1'b1;
  logic                     SCmdAccept = 1'b0;
  ocpPkg::sRespT            SResp = ocpPkg::respNull;
  logic [DataWidth-1:0]     SData = '0;

  int seed = 32'h2235;
  bit alwaysAccept = 1'b0;
  bit gateEnable = 1'b0;
  int testCount = 0;
  int failedTests = 0;
  int localErrors = 0;
  int errorMark = 0;

  ocpMaster #(
    .AddrWidth     (AddrWidth),
    .DataWidth     (DataWidth),
    .BurstLenWidth (BurstLenWidth)
  ) UUT (.*);

  always #5 Clk = ~Clk;

  // Slave model and clock enable, 1 ns after each rising edge
  always @(posedge Clk) begin
    #1;
    SCmdAccept = alwaysAccept || (($random(seed) & 1) == 1);
    EnableClk = !gateEnable || (($random(seed) & 3) != 0);
    // Random SResp walks all four codes
    SResp = ocpPkg::sRespT'($random(seed));
    SData = DataWidth'($random(seed));
  end

  function automatic int errorTotal();
    return UUT.checks.failCount + localErrors;
  endfunction

  task automatic reportTest(input string name);
    int errors;
    errors = errorTotal() - errorMark;
    testCount++;
    if (errors == 0) begin
      $display("%s: ok", name);
    end else begin
      failedTests++;
      $display("%s: FAILED with %0d errors", name, errors);
    end
    errorMark = errorTotal();
  endtask

  // One request, then count accepted beats until MCmd is idle again
  task automatic runBurst(input string name, input bit doRead, input bit doWrite,
                          input int length, input bit single);
    int beats;
    int cycles;
    int expected;
    bit started;
    bit finished;
    beats = 0;
    started = 1'b0;
    finished = 1'b0;
    expected = single ? 1 : length;
    @(posedge Clk);
    #1;
    readRequest = doRead;
    writeRequest = doWrite;
    burstLength = BurstLenWidth'(length);
    // Any MBurstSeq code runs as incrementing
    burstSeq = ocpPkg::burstSeqT'(length);
    burstSingleReq = single;
    for (cycles = 0; cycles < timeoutCycles && !finished; cycles++) begin
      // Mid-cycle, inputs and outputs settled
      @(negedge Clk);
      if (MCmd != ocpPkg::cmdIdle) begin
        started = 1'b1;
        if (EnableClk && SCmdAccept) begin
          beats++;
        end
      end else begin
        finished = started;
      end
      @(posedge Clk);
      #1;
      if (started) begin
        readRequest = 1'b0;
        writeRequest = 1'b0;
      end
      // Next beat's address and data
      address = address + AddrWidth'(1);
      writeData = DataWidth'($random(seed));
    end
    if (!finished) begin
      $display("%s: burst did not return to idle within %0d cycles", name, timeoutCycles);
      localErrors++;
      readRequest = 1'b0;
      writeRequest = 1'b0;
    end else if (beats != expected) begin
      $display("ERROR %s: expected %0d beats, actual %0d", name, expected, beats);
      localErrors++;
    end
    reportTest(name);
  endtask

  initial begin
    int len;
    reset = 1'b1;
    readRequest = 1'b0;
    writeRequest = 1'b0;
    burstSingleReq = 1'b0;
    address = AddrWidth'(32'h1000);
    writeData = '0;
    burstLength = BurstLenWidth'(1);
    burstSeq = ocpPkg::seqIncr;
    repeat (2) @(posedge Clk);
    #1;
    reset = 1'b0;
    // Idle, no request
    repeat (6) @(posedge Clk);
    reportTest("afterReset");
    for (len = 1; len <= 8; len++) begin
      runBurst($sformatf("write%0d", len), 1'b0, 1'b1, len, 1'b0);
    end
    for (len = 1; len <= 8; len++) begin
      runBurst($sformatf("read%0d", len), 1'b1, 1'b0, len, 1'b0);
    end
    runBurst("readPriority", 1'b1, 1'b1, 4, 1'b0);
    runBurst("singleWrite", 1'b0, 1'b1, 5, 1'b1);
    runBurst("singleRead", 1'b1, 1'b0, 3, 1'b1);
    // Accept held high while EnableClk drops at random
    alwaysAccept = 1'b1;
    gateEnable = 1'b1;
    runBurst("enableWrite", 1'b0, 1'b1, 6, 1'b0);
    runBurst("enableRead", 1'b1, 1'b0, 3, 1'b0);
    alwaysAccept = 1'b0;
    gateEnable = 1'b0;
    // readData decode under random SResp
    repeat (32) @(posedge Clk);
    reportTest("readResponses");
    repeat (2) @(posedge Clk);
    $display("%0d tests, %0d failed, %0d errors", testCount, failedTests, errorTotal());
    if (failedTests == 0 && errorTotal() == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- project.f
source/ocpPkg.sv
source/bridgePkg.sv
source/burstCounter.sv
source/requestFsm.sv
source/ocpMaster.sv
sim/ocpMaster_assert.sv
sim/ocpMasterTb.sv

//--- run.sh
#!/bin/sh
# Build and run the ocpMaster testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module ocpMasterTb \
  -f project.f -Mdir obj_dir -o ocpMasterSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/ocpMasterSim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
exit 0
